/* common/sb_pkg.sv */
package sb_pkg;

    localparam int NUM_FU   = 4;
    localparam int NUM_REGS = 32;

    typedef logic [31:0]       inst_t;
    typedef logic [4:0]        reg_idx_t;   // 0 means no register
    typedef logic [2:0]        fu_id_t;
    typedef logic [NUM_FU-1:0] fu_vec_t;    // bit = unit code - 1
    typedef logic [4:0]        fu_op_t;

    localparam fu_id_t FU_NONE = 3'd0;
    localparam fu_id_t FU_ALU  = 3'd1;
    localparam fu_id_t FU_MEM  = 3'd2;
    localparam fu_id_t FU_MUL  = 3'd3;
    localparam fu_id_t FU_DIV  = 3'd4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // alu, bit 4 set for the immediate form
    localparam fu_op_t ALU_ADD   = 5'h00;
    localparam fu_op_t ALU_SUB   = 5'h01;
    localparam fu_op_t ALU_SLL   = 5'h02;
    localparam fu_op_t ALU_SLT   = 5'h03;
    localparam fu_op_t ALU_SLTU  = 5'h04;
    localparam fu_op_t ALU_XOR   = 5'h05;
    localparam fu_op_t ALU_SRL   = 5'h06;
    localparam fu_op_t ALU_SRA   = 5'h07;
    localparam fu_op_t ALU_OR    = 5'h08;
    localparam fu_op_t ALU_AND   = 5'h09;
    localparam fu_op_t ALU_ADDI  = 5'h10;
    localparam fu_op_t ALU_SLLI  = 5'h12;
    localparam fu_op_t ALU_SLTI  = 5'h13;
    localparam fu_op_t ALU_SLTIU = 5'h14;
    localparam fu_op_t ALU_XORI  = 5'h15;
    localparam fu_op_t ALU_SRLI  = 5'h16;
    localparam fu_op_t ALU_SRAI  = 5'h17;
    localparam fu_op_t ALU_ORI   = 5'h18;
    localparam fu_op_t ALU_ANDI  = 5'h19;

    // mem is {funct3, store}
    localparam fu_op_t MEM_LB  = 5'b00000;
    localparam fu_op_t MEM_LH  = 5'b00010;
    localparam fu_op_t MEM_LW  = 5'b00100;
    localparam fu_op_t MEM_LBU = 5'b01000;
    localparam fu_op_t MEM_LHU = 5'b01010;
    localparam fu_op_t MEM_SB  = 5'b00001;
    localparam fu_op_t MEM_SH  = 5'b00011;
    localparam fu_op_t MEM_SW  = 5'b00101;

    localparam fu_op_t MUL_MUL    = 5'd0;
    localparam fu_op_t MUL_MULH   = 5'd1;
    localparam fu_op_t MUL_MULHSU = 5'd2;
    localparam fu_op_t MUL_MULHU  = 5'd3;

    localparam fu_op_t DIV_DIV  = 5'd0;
    localparam fu_op_t DIV_DIVU = 5'd1;
    localparam fu_op_t DIV_REM  = 5'd2;
    localparam fu_op_t DIV_REMU = 5'd3;

endpackage

/* design/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  sb_pkg::inst_t    inst,
    output sb_pkg::fu_id_t   fu_sel,
    output sb_pkg::fu_op_t   op,
    output sb_pkg::reg_idx_t dst,
    output sb_pkg::reg_idx_t src1,
    output sb_pkg::reg_idx_t src2
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_en;
    logic       use_rd;
    logic       use_rs2;
    sb_pkg::fu_op_t alu_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // funct7 only selects sub/sra, for immediates just on srai
    assign alt_en = (funct7 == sb_pkg::F7_ALT) &&
                    (opcode == sb_pkg::OPC_OP || funct3 == 3'd5);

    always_comb begin
        case (funct3)
            3'd0:    alu_op = alt_en ? sb_pkg::ALU_SUB : sb_pkg::ALU_ADD;
            3'd1:    alu_op = sb_pkg::ALU_SLL;
            3'd2:    alu_op = sb_pkg::ALU_SLT;
            3'd3:    alu_op = sb_pkg::ALU_SLTU;
            3'd4:    alu_op = sb_pkg::ALU_XOR;
            3'd5:    alu_op = alt_en ? sb_pkg::ALU_SRA : sb_pkg::ALU_SRL;
            3'd6:    alu_op = sb_pkg::ALU_OR;
            default: alu_op = sb_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        fu_sel  = sb_pkg::FU_NONE;
        op      = '0;
        use_rd  = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            sb_pkg::OPC_OP: begin
                use_rd  = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == sb_pkg::F7_MULDIV) begin
                    fu_sel = funct3[2] ? sb_pkg::FU_DIV : sb_pkg::FU_MUL;
                    op     = {3'b000, funct3[1:0]};
                end else if (funct7 == sb_pkg::F7_BASE ||
                             (alt_en && (funct3 == 3'd0 || funct3 == 3'd5))) begin
                    fu_sel = sb_pkg::FU_ALU;
                    op     = alu_op;
                end
            end
            sb_pkg::OPC_OP_IMM: begin
                use_rd = 1'b1;
                // shifts need a clean funct7
                if ((funct3 != 3'd1 && funct3 != 3'd5) ||
                    funct7 == sb_pkg::F7_BASE || alt_en) begin
                    fu_sel = sb_pkg::FU_ALU;
                    op     = {1'b1, alu_op[3:0]};
                end
            end
            sb_pkg::OPC_LOAD: begin
                use_rd = 1'b1;
                if (funct3 != 3'd3 && funct3 < 3'd6) begin
                    fu_sel = sb_pkg::FU_MEM;
                    op     = {1'b0, funct3, 1'b0};
                end
            end
            sb_pkg::OPC_STORE: begin
                use_rs2 = 1'b1;
                if (funct3 < 3'd3) begin
                    fu_sel = sb_pkg::FU_MEM;
                    op     = {1'b0, funct3, 1'b1};
                end
            end
            default: ;
        endcase
    end

    assign dst  = (fu_sel != sb_pkg::FU_NONE && use_rd) ? inst[11:7] : '0;
    assign src1 = (fu_sel != sb_pkg::FU_NONE) ? inst[19:15] : '0;
    assign src2 = (fu_sel != sb_pkg::FU_NONE && use_rs2) ? inst[24:20] : '0;

endmodule

/* scoreboard/fu_status_table.sv */
`timescale 1ns/1ps

module fu_status_table (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     inst_valid,
    input  sb_pkg::fu_id_t                           fu_sel,
    input  sb_pkg::fu_op_t                           op,
    input  sb_pkg::reg_idx_t                         dst,
    input  sb_pkg::reg_idx_t                         src1,
    input  sb_pkg::reg_idx_t                         src2,
    input  sb_pkg::fu_vec_t                          dispatch_grant,
    input  sb_pkg::fu_id_t                           retire_fu,
    input  sb_pkg::fu_vec_t                          done_in,
    output logic                                     issue_ready,
    output sb_pkg::fu_vec_t                          busy,
    output sb_pkg::fu_vec_t                          rdy1,
    output sb_pkg::fu_vec_t                          rdy2,
    output sb_pkg::fu_vec_t                          done_q,
    output sb_pkg::fu_op_t   [sb_pkg::NUM_FU-1:0]    op_q,
    output sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    dst_q,
    output sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    src1_q,
    output sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    src2_q,
    output sb_pkg::fu_id_t   [sb_pkg::NUM_FU-1:0]    qj,
    output sb_pkg::fu_id_t   [sb_pkg::NUM_FU-1:0]    qk
);
    sb_pkg::fu_id_t  rrs [sb_pkg::NUM_REGS];   // pending writer per register
    sb_pkg::fu_vec_t sel_vec;
    sb_pkg::fu_vec_t retire_vec;
    sb_pkg::fu_id_t  tag1;
    sb_pkg::fu_id_t  tag2;
    logic            struct_hz;
    logic            waw_hz;
    logic            issue;

    always_comb begin
        for (int i = 0; i < sb_pkg::NUM_FU; i++) begin
            sel_vec[i]    = fu_sel == sb_pkg::fu_id_t'(i + 1);
            retire_vec[i] = retire_fu == sb_pkg::fu_id_t'(i + 1);
        end
    end

    assign struct_hz   = |(sel_vec & busy);
    assign waw_hz      = (dst != '0) && (rrs[dst] != sb_pkg::FU_NONE);
    assign issue_ready = ~struct_hz & ~waw_hz;
    assign issue       = inst_valid & issue_ready & (fu_sel != sb_pkg::FU_NONE);

    // a producer retiring on this edge already counts as written
    assign tag1 = (rrs[src1] == retire_fu) ? sb_pkg::FU_NONE : rrs[src1];
    assign tag2 = (rrs[src2] == retire_fu) ? sb_pkg::FU_NONE : rrs[src2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= '0;
            rdy1   <= '0;
            rdy2   <= '0;
            done_q <= '0;
            op_q   <= '0;
            dst_q  <= '0;
            src1_q <= '0;
            src2_q <= '0;
            qj     <= '0;
            qk     <= '0;
            for (int r = 0; r < sb_pkg::NUM_REGS; r++) begin
                rrs[r] <= sb_pkg::FU_NONE;
            end
        end else begin
            done_q <= done_in & busy & ~retire_vec;   // unit still holds done while retiring
            for (int i = 0; i < sb_pkg::NUM_FU; i++) begin
                if (dispatch_grant[i]) begin
                    rdy1[i]   <= 1'b0;
                    rdy2[i]   <= 1'b0;
                    // operands read, no longer a WAR reader
                    src1_q[i] <= '0;
                    src2_q[i] <= '0;
                end
                if (retire_vec[i]) begin
                    busy[i]   <= 1'b0;
                    rdy1[i]   <= 1'b0;
                    rdy2[i]   <= 1'b0;
                    op_q[i]   <= '0;
                    dst_q[i]  <= '0;
                    src1_q[i] <= '0;
                    src2_q[i] <= '0;
                    qj[i]     <= sb_pkg::FU_NONE;
                    qk[i]     <= sb_pkg::FU_NONE;
                    rrs[dst_q[i]] <= sb_pkg::FU_NONE;
                end
                // wake readers waiting on the retiring unit
                if (retire_fu != sb_pkg::FU_NONE && qj[i] == retire_fu) begin
                    qj[i]   <= sb_pkg::FU_NONE;
                    rdy1[i] <= 1'b1;
                end
                if (retire_fu != sb_pkg::FU_NONE && qk[i] == retire_fu) begin
                    qk[i]   <= sb_pkg::FU_NONE;
                    rdy2[i] <= 1'b1;
                end
                if (issue && sel_vec[i]) begin
                    busy[i]   <= 1'b1;
                    op_q[i]   <= op;
                    dst_q[i]  <= dst;
                    src1_q[i] <= src1;
                    src2_q[i] <= src2;
                    qj[i]     <= tag1;
                    qk[i]     <= tag2;
                    rdy1[i]   <= tag1 == sb_pkg::FU_NONE;
                    rdy2[i]   <= tag2 == sb_pkg::FU_NONE;
                end
            end
            if (issue && dst != '0) begin
                rrs[dst] <= fu_sel;
            end
        end
    end

endmodule

/* scoreboard/operand_dispatch.sv */
`timescale 1ns/1ps

module operand_dispatch (
    input  sb_pkg::fu_vec_t                          rdy1,
    input  sb_pkg::fu_vec_t                          rdy2,
    input  sb_pkg::fu_op_t   [sb_pkg::NUM_FU-1:0]    op_q,
    input  sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    src1_q,
    input  sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    src2_q,
    output sb_pkg::fu_vec_t                          dispatch_grant,
    output sb_pkg::fu_vec_t                          fu_en,
    output sb_pkg::fu_op_t                           op_ctrl,
    output sb_pkg::reg_idx_t                         rs1_ctrl,
    output sb_pkg::reg_idx_t                         rs2_ctrl
);

    // walk from the lowest priority up, so alu wins last
    always_comb begin
        dispatch_grant = '0;
        op_ctrl        = '0;
        rs1_ctrl       = '0;
        rs2_ctrl       = '0;
        for (int i = sb_pkg::NUM_FU - 1; i >= 0; i--) begin
            if (rdy1[i] && rdy2[i]) begin
                dispatch_grant    = '0;
                dispatch_grant[i] = 1'b1;
                op_ctrl           = op_q[i];
                rs1_ctrl          = src1_q[i];
                rs2_ctrl          = src2_q[i];
            end
        end
    end

    assign fu_en = dispatch_grant;   // one-hot enable to the units

endmodule

/* scoreboard/writeback_arbiter.sv */
`timescale 1ns/1ps

module writeback_arbiter (
    input  sb_pkg::fu_vec_t                          done_q,
    input  sb_pkg::fu_vec_t                          busy,
    input  sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    dst_q,
    input  sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    src1_q,
    input  sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0]    src2_q,
    input  sb_pkg::fu_id_t   [sb_pkg::NUM_FU-1:0]    qj,
    input  sb_pkg::fu_id_t   [sb_pkg::NUM_FU-1:0]    qk,
    output sb_pkg::fu_id_t                           retire_fu,
    output logic                                     reg_write,
    output sb_pkg::reg_idx_t                         rd_ctrl
);
    sb_pkg::fu_vec_t war_ok;
    sb_pkg::fu_vec_t can_retire;

    // a reader with no producer tag and a live source has not read yet
    always_comb begin
        for (int i = 0; i < sb_pkg::NUM_FU; i++) begin
            war_ok[i] = 1'b1;
            for (int j = 0; j < sb_pkg::NUM_FU; j++) begin
                if (j != i && busy[j] && dst_q[i] != '0) begin
                    if ((qj[j] == sb_pkg::FU_NONE && src1_q[j] == dst_q[i]) ||
                        (qk[j] == sb_pkg::FU_NONE && src2_q[j] == dst_q[i])) begin
                        war_ok[i] = 1'b0;
                    end
                end
            end
        end
    end

    assign can_retire = done_q & busy & war_ok;

    always_comb begin
        retire_fu = sb_pkg::FU_NONE;
        rd_ctrl   = '0;
        for (int i = sb_pkg::NUM_FU - 1; i >= 0; i--) begin
            if (can_retire[i]) begin
                retire_fu = sb_pkg::fu_id_t'(i + 1);
                rd_ctrl   = dst_q[i];
            end
        end
    end

    assign reg_write = rd_ctrl != '0;   // stores carry no destination

endmodule

/* design/sb_top.sv */
`timescale 1ns/1ps

module sb_top (
    input  logic             clk,
    input  logic             rst,
    input  sb_pkg::inst_t    inst,
    input  logic             inst_valid,
    input  sb_pkg::fu_vec_t  fu_done,
    output logic             issue_ready,
    output sb_pkg::fu_vec_t  fu_en,
    output sb_pkg::fu_op_t   op_ctrl,
    output sb_pkg::reg_idx_t rs1_ctrl,
    output sb_pkg::reg_idx_t rs2_ctrl,
    output sb_pkg::fu_id_t   write_sel,
    output logic             reg_write,
    output sb_pkg::reg_idx_t rd_ctrl
);
    sb_pkg::fu_id_t   fu_sel;
    sb_pkg::fu_op_t   op;
    sb_pkg::reg_idx_t dst;
    sb_pkg::reg_idx_t src1;
    sb_pkg::reg_idx_t src2;
    sb_pkg::fu_vec_t  dispatch_grant;
    sb_pkg::fu_vec_t  busy;
    sb_pkg::fu_vec_t  rdy1;
    sb_pkg::fu_vec_t  rdy2;
    sb_pkg::fu_vec_t  done_q;
    sb_pkg::fu_op_t   [sb_pkg::NUM_FU-1:0] op_q;
    sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0] dst_q;
    sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0] src1_q;
    sb_pkg::reg_idx_t [sb_pkg::NUM_FU-1:0] src2_q;
    sb_pkg::fu_id_t   [sb_pkg::NUM_FU-1:0] qj;
    sb_pkg::fu_id_t   [sb_pkg::NUM_FU-1:0] qk;

    inst_decode inst_decode_inst (
        .inst(inst), .fu_sel(fu_sel), .op(op), .dst(dst), .src1(src1), .src2(src2)
    );

    fu_status_table fu_status_table_inst (
        .clk(clk), .rst(rst), .inst_valid(inst_valid),
        .fu_sel(fu_sel), .op(op), .dst(dst), .src1(src1), .src2(src2),
        .dispatch_grant(dispatch_grant), .retire_fu(write_sel), .done_in(fu_done),
        .issue_ready(issue_ready), .busy(busy), .rdy1(rdy1), .rdy2(rdy2), .done_q(done_q),
        .op_q(op_q), .dst_q(dst_q), .src1_q(src1_q), .src2_q(src2_q), .qj(qj), .qk(qk)
    );

    operand_dispatch operand_dispatch_inst (
        .rdy1(rdy1), .rdy2(rdy2), .op_q(op_q), .src1_q(src1_q), .src2_q(src2_q),
        .dispatch_grant(dispatch_grant), .fu_en(fu_en), .op_ctrl(op_ctrl),
        .rs1_ctrl(rs1_ctrl), .rs2_ctrl(rs2_ctrl)
    );

    writeback_arbiter writeback_arbiter_inst (
        .done_q(done_q), .busy(busy), .dst_q(dst_q), .src1_q(src1_q), .src2_q(src2_q),
        .qj(qj), .qk(qk), .retire_fu(write_sel), .reg_write(reg_write), .rd_ctrl(rd_ctrl)
    );

endmodule

/* verification/sb_props.sv */
`timescale 1ns/1ps

module sb_props (
    input logic             clk,
    input logic             rst,
    input sb_pkg::fu_vec_t  fu_en,
    input sb_pkg::fu_vec_t  busy,
    input sb_pkg::fu_vec_t  fu_done,
    input sb_pkg::fu_id_t   write_sel
);

    // enables only go to occupied units
    a_en_busy: assert property (@(posedge clk) disable iff (rst) (fu_en & ~busy) == '0)
        else $error("enable to an idle unit");

    a_en_once: assert property (@(posedge clk) disable iff (rst) (fu_en & $past(fu_en)) == '0)
        else $error("unit enabled in two cycles in a row");

    // done is registered before a unit can retire
    a_retire_done: assert property (@(posedge clk) disable iff (rst)
        write_sel != sb_pkg::FU_NONE |->
        ($past(fu_done) & (sb_pkg::fu_vec_t'(1) << (write_sel - 1))) != '0)
        else $error("unit retired without done in the cycle before");

    a_retire_once: assert property (@(posedge clk) disable iff (rst)
        write_sel != sb_pkg::FU_NONE |=> write_sel != $past(write_sel))
        else $error("unit retired in two cycles in a row");

endmodule

bind sb_top sb_props sb_props_inst (
    .clk(clk), .rst(rst), .fu_en(fu_en), .busy(busy), .fu_done(fu_done),
    .write_sel(write_sel)
);

/* verification/sb_tb.sv */
`timescale 1ns/1ps

module sb_tb;
    localparam int N_INST = 200;
    localparam int T      = 20;

    logic             clk;
    logic             rst;
    sb_pkg::inst_t    inst;
    logic             inst_valid;
    sb_pkg::fu_vec_t  fu_done;
    logic             issue_ready;
    sb_pkg::fu_vec_t  fu_en;
    sb_pkg::fu_op_t   op_ctrl;
    sb_pkg::reg_idx_t rs1_ctrl;
    sb_pkg::reg_idx_t rs2_ctrl;
    sb_pkg::fu_id_t   write_sel;
    logic             reg_write;
    sb_pkg::reg_idx_t rd_ctrl;

    logic [31:0]      lfsr;
    int               errs [1:6];
    int               n_checks;
    int               n_taken;
    int               n_issued;
    int               n_retired;
    logic             have_inst;
    // expected decode of the word on inst
    sb_pkg::fu_id_t   e_fu;
    sb_pkg::fu_op_t   e_op;
    sb_pkg::reg_idx_t e_dst;
    sb_pkg::reg_idx_t e_s1;
    sb_pkg::reg_idx_t e_s2;
    // model, one slot per unit
    logic             m_busy [4];
    logic             m_disp [4];
    logic             m_doneq [4];
    sb_pkg::fu_op_t   m_op [4];
    sb_pkg::reg_idx_t m_dst [4];
    sb_pkg::reg_idx_t m_src1 [4];
    sb_pkg::reg_idx_t m_src2 [4];
    int               m_wait1 [4];   // producer unit code, 0 when none
    int               m_wait2 [4];
    int               rcnt [4];
    logic             rdone [4];

    sb_top sb_top_inst (
        .clk(clk), .rst(rst), .inst(inst), .inst_valid(inst_valid), .fu_done(fu_done),
        .issue_ready(issue_ready), .fu_en(fu_en), .op_ctrl(op_ctrl), .rs1_ctrl(rs1_ctrl),
        .rs2_ctrl(rs2_ctrl), .write_sel(write_sel), .reg_write(reg_write), .rd_ctrl(rd_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(T/2) clk = ~clk;
    end

    initial begin
        repeat (N_INST * 40) @(posedge clk);
        $display("watchdog expired, scoreboard stopped making progress");
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp, input int b);
        n_checks++;
        if (got !== exp) begin
            errs[b]++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic sb_pkg::fu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? sb_pkg::ALU_SUB : sb_pkg::ALU_ADD;
            3'd1:    return sb_pkg::ALU_SLL;
            3'd2:    return sb_pkg::ALU_SLT;
            3'd3:    return sb_pkg::ALU_SLTU;
            3'd4:    return sb_pkg::ALU_XOR;
            3'd5:    return alt ? sb_pkg::ALU_SRA : sb_pkg::ALU_SRL;
            3'd6:    return sb_pkg::ALU_OR;
            default: return sb_pkg::ALU_AND;
        endcase
    endfunction

    function automatic sb_pkg::fu_op_t mem_op_of(input logic [2:0] f3, input logic store);
        case (f3)
            3'd0:    return store ? sb_pkg::MEM_SB : sb_pkg::MEM_LB;
            3'd1:    return store ? sb_pkg::MEM_SH : sb_pkg::MEM_LH;
            3'd2:    return store ? sb_pkg::MEM_SW : sb_pkg::MEM_LW;
            3'd4:    return sb_pkg::MEM_LBU;
            default: return sb_pkg::MEM_LHU;
        endcase
    endfunction

    // funct3[2] picks div over mul
    function automatic sb_pkg::fu_op_t muldiv_op_of(input logic [2:0] f3);
        case (f3)
            3'd0:    return sb_pkg::MUL_MUL;
            3'd1:    return sb_pkg::MUL_MULH;
            3'd2:    return sb_pkg::MUL_MULHSU;
            3'd3:    return sb_pkg::MUL_MULHU;
            3'd4:    return sb_pkg::DIV_DIV;
            3'd5:    return sb_pkg::DIV_DIVU;
            3'd6:    return sb_pkg::DIV_REM;
            default: return sb_pkg::DIV_REMU;
        endcase
    endfunction

    // small register pool, so hazards show up often
    task automatic make_inst();
        logic [2:0]       kind;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic             alt;
        sb_pkg::reg_idx_t rd;
        sb_pkg::reg_idx_t rs1;
        sb_pkg::reg_idx_t rs2;
        kind  = 3'(take_bits(3));
        f3    = 3'(take_bits(3));
        rd    = 5'(take_bits(2));
        rs1   = 5'(take_bits(2));
        rs2   = 5'(take_bits(2));
        f7    = 7'(take_bits(7));
        alt   = 1'b0;
        e_dst = rd;
        e_s1  = rs1;
        e_s2  = '0;
        case (kind)
            3'd0, 3'd1: begin
                alt  = (f3 == 3'd0 || f3 == 3'd5) && take_bits(1) != 0;
                f7   = alt ? sb_pkg::F7_ALT : sb_pkg::F7_BASE;
                inst = {f7, rs2, rs1, f3, rd, sb_pkg::OPC_OP};
                e_fu = sb_pkg::FU_ALU;
                e_op = alu_op_of(f3, alt);
                e_s2 = rs2;
            end
            3'd2: begin
                if (f3 == 3'd1) f7 = sb_pkg::F7_BASE;
                if (f3 == 3'd5) begin
                    alt = f7[0];
                    f7  = alt ? sb_pkg::F7_ALT : sb_pkg::F7_BASE;
                end
                inst = {f7, rs2, rs1, f3, rd, sb_pkg::OPC_OP_IMM};
                e_fu = sb_pkg::FU_ALU;
                e_op = alu_op_of(f3, alt) | 5'h10;
            end
            3'd3: begin
                if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'd2;
                inst = {f7, rs2, rs1, f3, rd, sb_pkg::OPC_LOAD};
                e_fu = sb_pkg::FU_MEM;
                e_op = mem_op_of(f3, 1'b0);
            end
            3'd4: begin
                f3    = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
                inst  = {f7, rs2, rs1, f3, rd, sb_pkg::OPC_STORE};
                e_fu  = sb_pkg::FU_MEM;
                e_op  = mem_op_of(f3, 1'b1);
                e_dst = '0;
                e_s2  = rs2;
            end
            3'd5, 3'd6: begin
                f3   = {kind == 3'd6, f3[1:0]};
                inst = {sb_pkg::F7_MULDIV, rs2, rs1, f3, rd, sb_pkg::OPC_OP};
                e_fu = (kind == 3'd6) ? sb_pkg::FU_DIV : sb_pkg::FU_MUL;
                e_op = muldiv_op_of(f3);
                e_s2 = rs2;
            end
            default: begin
                inst  = {f7, rs2, rs1, f3, rd, 7'b0110111};   // lui, not handled
                e_fu  = sb_pkg::FU_NONE;
                e_op  = '0;
                e_dst = '0;
                e_s1  = '0;
            end
        endcase
    endtask

    function automatic int producer(input sb_pkg::reg_idx_t r);
        if (r == '0) return 0;
        for (int j = 0; j < 4; j++) begin
            if (m_busy[j] && m_dst[j] == r) return j + 1;
        end
        return 0;
    endfunction

    // no undispatched reader still needs the old value
    function automatic logic war_ok(input int u);
        for (int j = 0; j < 4; j++) begin
            if (j != u && m_busy[j] && !m_disp[j] && m_dst[u] != '0) begin
                if ((m_wait1[j] == 0 && m_src1[j] == m_dst[u]) ||
                    (m_wait2[j] == 0 && m_src2[j] == m_dst[u])) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic any_busy();
        return m_busy[0] | m_busy[1] | m_busy[2] | m_busy[3];
    endfunction

    task automatic sample_and_update(output logic taken);
        sb_pkg::fu_vec_t exp_en;
        sb_pkg::fu_id_t  exp_ret;
        logic            exp_ready;
        int              u;
        exp_en  = '0;
        exp_ret = sb_pkg::FU_NONE;
        for (int i = 3; i >= 0; i--) begin
            if (m_busy[i] && !m_disp[i] && m_wait1[i] == 0 && m_wait2[i] == 0)
                exp_en = sb_pkg::fu_vec_t'(1) << i;
            if (m_busy[i] && m_doneq[i] && war_ok(i))
                exp_ret = sb_pkg::fu_id_t'(i + 1);
        end
        check("fu_en", fu_en, exp_en, 2);
        for (int i = 0; i < 4; i++) begin
            if (fu_en[i]) begin
                if (!m_busy[i] || m_disp[i]) begin
                    errs[2]++;
                    $display("unit %0d enabled with no instruction waiting at %0t", i, $time);
                end
                if (m_wait1[i] != 0 || m_wait2[i] != 0) begin
                    errs[4]++;
                    $display("unit %0d enabled before its source was written", i);
                end
                check("op_ctrl", op_ctrl, m_op[i], 2);
                check("rs1_ctrl", rs1_ctrl, m_src1[i], 2);
                check("rs2_ctrl", rs2_ctrl, m_src2[i], 2);
            end
        end
        if (fu_en == '0) begin
            check("op_ctrl", op_ctrl, 0, 2);
            check("rs1_ctrl", rs1_ctrl, 0, 2);
            check("rs2_ctrl", rs2_ctrl, 0, 2);
        end
        if (write_sel != 0 && write_sel <= 4 && !war_ok(int'(write_sel) - 1)) begin
            errs[6]++;
            $display("unit %0d retired while a reader still needs its register", write_sel);
        end
        check("write_sel", write_sel, exp_ret, 5);
        if (exp_ret != 0) begin
            check("rd_ctrl", rd_ctrl, m_dst[exp_ret - 1], 5);
            check("reg_write", reg_write, m_dst[exp_ret - 1] != '0, 5);
        end
        exp_ready = !(e_fu != 0 && m_busy[e_fu - 1]) && !(e_dst != 0 && producer(e_dst) != 0);
        check("issue_ready", issue_ready, exp_ready, 3);
        taken = inst_valid && issue_ready;

        for (int i = 0; i < 4; i++) begin
            m_doneq[i] = fu_done[i] && m_busy[i] && (exp_ret != sb_pkg::fu_id_t'(i + 1));
            if (write_sel == sb_pkg::fu_id_t'(i + 1)) begin
                rdone[i] = 1'b0;
            end else if (rcnt[i] > 0) begin
                rcnt[i]--;
                if (rcnt[i] == 0) rdone[i] = 1'b1;
            end
            if (fu_en[i]) begin
                rcnt[i] = 1 + int'(take_bits(2));   // unit starts its work
            end
            if (exp_en[i]) begin
                m_disp[i] = 1'b1;
            end
        end
        if (write_sel != sb_pkg::FU_NONE) n_retired++;
        if (exp_ret != sb_pkg::FU_NONE) begin
            m_busy[exp_ret - 1] = 1'b0;
            for (int j = 0; j < 4; j++) begin
                if (m_wait1[j] == int'(exp_ret)) m_wait1[j] = 0;
                if (m_wait2[j] == int'(exp_ret)) m_wait2[j] = 0;
            end
        end
        if (taken && e_fu != 0) begin
            u          = int'(e_fu) - 1;
            m_wait1[u] = producer(e_s1);
            m_wait2[u] = producer(e_s2);
            m_busy[u]  = 1'b1;
            m_disp[u]  = 1'b0;
            m_op[u]    = e_op;
            m_dst[u]   = e_dst;
            m_src1[u]  = e_s1;
            m_src2[u]  = e_s2;
            n_issued++;
        end
    endtask

    initial begin
        logic taken;
        int   total;
        lfsr       = 32'h1c7da914;
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        fu_done    = '0;
        taken      = 1'b0;
        n_checks   = 0;
        n_taken    = 0;
        n_issued   = 0;
        n_retired  = 0;
        total      = 0;
        for (int b = 1; b <= 6; b++) errs[b] = 0;
        for (int i = 0; i < 4; i++) begin
            m_busy[i]  = 1'b0;
            m_disp[i]  = 1'b0;
            m_doneq[i] = 1'b0;
            m_wait1[i] = 0;
            m_wait2[i] = 0;
            rcnt[i]    = 0;
            rdone[i]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        make_inst();
        have_inst = 1'b1;
        #(T/4);
        check("fu_en", fu_en, 0, 1);
        check("write_sel", write_sel, 0, 1);
        check("reg_write", reg_write, 0, 1);
        check("issue_ready", issue_ready, 1, 1);
        $display("behavior 1 reset state: %0d errors", errs[1]);
        while (have_inst || any_busy()) begin
            @(negedge clk);
            // next word only after the edge that took the last one
            if (taken) begin
                n_taken++;
                if (n_taken < N_INST) make_inst();
                else have_inst = 1'b0;
            end
            inst_valid = have_inst && take_bits(2) != 0;
            fu_done    = {rdone[3], rdone[2], rdone[1], rdone[0]};
            #(T/4);
            sample_and_update(taken);
        end
        check("retired count", n_retired, n_issued, 5);
        for (int b = 2; b <= 6; b++) begin
            $display("behavior %0d: %0d errors", b, errs[b]);
        end
        for (int b = 1; b <= 6; b++) total += errs[b];
        $display("%0d taken, %0d issued, %0d checks, %0d errors",
                 n_taken, n_issued, n_checks, total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
common/sb_pkg.sv
design/inst_decode.sv
scoreboard/fu_status_table.sv
scoreboard/operand_dispatch.sv
scoreboard/writeback_arbiter.sv
design/sb_top.sv
verification/sb_props.sv
verification/sb_tb.sv

/* Makefile */
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module sb_tb -Mdir $(OBJ) -f verilog.f

run: compile
	./$(OBJ)/Vsb_tb > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
